// ==== project.f ====
+incdir+src
src/jtimer_pkg.sv
src/bit_scan.sv
src/leading_one_trailing_one.sv
src/timer_if.sv
src/johnson_counter.sv
src/johnson_decode.sv
src/interval_fsm.sv
src/interval_capture.sv
src/jtimer_top.sv
verification/tb_jtimer.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the tick interval timer testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_jtimer \
    -o tb_jtimer

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/tb_jtimer

// ==== verification/tb_jtimer.sv ====
// Self-checking testbench for the tick interval timer top level
// Runs a table of intervals and checks elapsed, overflow, done and busy
`timescale 1ns/100ps
`default_nettype none

module tb_jtimer;
    import jtimer_pkg::*;

    // ------------------------------------------------------------------------
    // Timing and sizes
    // ------------------------------------------------------------------------
    localparam int  HALF_PERIOD  = 50;
    localparam int  PERIOD       = 2 * HALF_PERIOD;
    localparam int  DRIVE_DELAY  = 5;
    localparam int  RESET_CYCLES = 10;
    localparam int  STEPS        = 2 * JT_WIDTH;
    localparam int  WRAP_MAX     = (1 << WRAP_BITS) - 1;
    localparam int  NUM_TESTS    = 25;
    localparam int  MAX_GAP      = 3;
    localparam int  DONE_LIMIT   = 4;
    // Start, stop, done and idle cycles around each interval
    localparam int  RUN_OVERHEAD = 8 + DONE_LIMIT;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     start;
    logic     stop;
    logic     tick;
    elapsed_t elapsed;
    logic     overflow;
    logic     code_error;
    logic     done;
    logic     busy;

    integer seed = 32'h5531;
    bit     table_ready = 1'b0;

    // Stimulus table, one interval per entry
    int tab_ticks         [NUM_TESTS];
    bit tab_gaps          [NUM_TESTS];
    bit tab_tick_at_start [NUM_TESTS];
    bit tab_tick_at_stop  [NUM_TESTS];
    bit tab_restart       [NUM_TESTS];

    jtimer_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .stop       (stop),
        .tick       (tick),
        .elapsed    (elapsed),
        .overflow   (overflow),
        .code_error (code_error),
        .done       (done),
        .busy       (busy)
    );

    always #HALF_PERIOD clk = ~clk;

    // ------------------------------------------------------------------------
    // Failure reporting and checks
    // ------------------------------------------------------------------------
    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input int exp, input int got);
        assert (exp == got) else begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, got);
            abort_run();
        end
    endtask

    // Counted ticks folded into wrap count and position, wrap count saturates
    function automatic int model_elapsed(input int counted);
        int wraps;
        wraps = counted / STEPS;
        if (wraps > WRAP_MAX) begin
            wraps = WRAP_MAX;
        end
        return wraps * STEPS + (counted % STEPS);
    endfunction

    // Overflow once a wrap is needed beyond the top wrap count
    function automatic bit model_overflow(input int counted);
        return (counted / STEPS) > WRAP_MAX;
    endfunction

    // ------------------------------------------------------------------------
    // Table
    // ------------------------------------------------------------------------
    task automatic add_entry(input int idx, input int ticks, input bit gaps,
                             input bit at_start, input bit at_stop, input bit restart);
        tab_ticks[idx]         = ticks;
        tab_gaps[idx]          = gaps;
        tab_tick_at_start[idx] = at_start;
        tab_tick_at_stop[idx]  = at_stop;
        tab_restart[idx]       = restart;
    endtask

    task automatic build_table();
        // Every position of one cycle, the all-ones code and the first wrap
        for (int i = 0; i <= STEPS + 1; i++) begin
            add_entry(i, i, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        add_entry(18, 5, 1'b1, 1'b0, 1'b0, 1'b0);
        // Ticks in the start and stop cycles are dropped
        add_entry(19, 12, 1'b1, 1'b0, 1'b1, 1'b0);
        add_entry(20, 9, 1'b0, 1'b1, 1'b0, 1'b0);
        // Start pulse in the middle of a run
        add_entry(21, 20, 1'b1, 1'b1, 1'b1, 1'b1);
        // Top of the wrap range, then past it
        add_entry(22, (WRAP_MAX + 1) * STEPS - 1, 1'b0, 1'b0, 1'b0, 1'b0);
        add_entry(23, (WRAP_MAX + 1) * STEPS, 1'b0, 1'b0, 1'b0, 1'b0);
        add_entry(24, (WRAP_MAX + 1) * STEPS + 44, 1'b1, 1'b0, 1'b1, 1'b0);
        table_ready = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // One interval
    // ------------------------------------------------------------------------
    task automatic run_interval(input int idx);
        int n;
        int gap;
        int latency;
        n = tab_ticks[idx];
        // Arm, a tick here must not count
        start = 1'b1;
        tick  = tab_tick_at_start[idx];
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        tick  = 1'b0;
        check_value("busy", 1, int'(busy));
        for (int i = 0; i < n; i++) begin
            gap = 0;
            if (tab_gaps[idx]) begin
                gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            end
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            tick  = 1'b1;
            // Restart request rides on a counted tick
            start = tab_restart[idx] && (i == n / 2);
            @(posedge clk);
            #DRIVE_DELAY;
            tick  = 1'b0;
            start = 1'b0;
        end
        // Stop, with an optional tick that must be dropped
        stop = 1'b1;
        tick = tab_tick_at_stop[idx];
        check_value("done", 0, int'(done));
        latency = 0;
        while (!done && latency < DONE_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            latency++;
            stop = 1'b0;
            tick = 1'b0;
        end
        assert (done) else begin
            $display("done did not arrive within %0d cycles of stop in entry %0d",
                     DONE_LIMIT, idx);
            abort_run();
        end
        check_value("done latency", 1, latency);
        check_value("elapsed", model_elapsed(n), int'(elapsed));
        check_value("overflow", int'(model_overflow(n)), int'(overflow));
        check_value("code_error", 0, int'(code_error));
        check_value("busy", 0, int'(busy));
        // Pulse is a single cycle wide
        @(posedge clk);
        #DRIVE_DELAY;
        check_value("done", 0, int'(done));
    endtask

    // ------------------------------------------------------------------------
    // Watchdog sized from the table
    // ------------------------------------------------------------------------
    initial begin
        int max_ticks;
        int limit;
        wait (table_ready);
        max_ticks = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (tab_ticks[i] > max_ticks) begin
                max_ticks = tab_ticks[i];
            end
        end
        limit = RESET_CYCLES + 2 + NUM_TESTS * (max_ticks * (MAX_GAP + 1) + RUN_OVERHEAD);
        #(limit * PERIOD);
        $display("watchdog expired after %0d cycles before the table finished", limit);
        abort_run();
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        stop  = 1'b0;
        tick  = 1'b0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        // Reset state
        check_value("busy", 0, int'(busy));
        check_value("done", 0, int'(done));
        check_value("elapsed", 0, int'(elapsed));
        check_value("overflow", 0, int'(overflow));
        check_value("code_error", 0, int'(code_error));
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_interval(i);
        end
        $display("all tests passed");
        $finish;
    end

endmodule : tb_jtimer

`default_nettype wire

// ==== src/jtimer_top.sv ====
// Tick interval timer top level with plain strobe and result ports
// Start arms, tick advances, stop captures the elapsed count
`timescale 1ns/100ps
`default_nettype none

`include "jtimer_config.svh"

module jtimer_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 stop,
    input  logic                 tick,
    output jtimer_pkg::elapsed_t elapsed,
    output logic                 overflow,
    output logic                 code_error,
    output logic                 done,
    output logic                 busy
);
    import jtimer_pkg::*;

    logic capture;
    pos_t position;
    logic dec_error;

    // Elapsed packing needs a power-of-two cycle length
    if ((`JT_WIDTH < 2) || ((1 << $clog2(2 * `JT_WIDTH)) != (2 * `JT_WIDTH))) begin : g_bad_cfg
        $error("JT_WIDTH must be at least 2 and 2*JT_WIDTH a power of two");
    end

    // Shared counter control and state
    timer_if bus ();

    // ------------------------------------------------------------------------
    // Control, count, decode, capture
    // ------------------------------------------------------------------------
    interval_fsm u_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .stop    (stop),
        .tick    (tick),
        .bus     (bus.ctrl),
        .capture (capture),
        .busy    (busy)
    );

    johnson_counter u_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.cnt)
    );

    johnson_decode u_decode (
        .bus        (bus.dec),
        .position   (position),
        .code_error (dec_error)
    );

    interval_capture u_capture (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture       (capture),
        .position      (position),
        .wrap_count    (bus.wrap_count),
        .wrap_sat      (bus.wrap_sat),
        .code_error_in (dec_error),
        .elapsed       (elapsed),
        .overflow      (overflow),
        .code_error    (code_error),
        .done          (done)
    );

endmodule : jtimer_top

`default_nettype wire

// ==== src/interval_capture.sv ====
// Result registers for the interval timer
// Loads elapsed count and flags on capture and pulses done one cycle later
`timescale 1ns/100ps
`default_nettype none

module interval_capture (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 capture,
    input  jtimer_pkg::pos_t     position,
    input  jtimer_pkg::wrap_t    wrap_count,
    input  logic                 wrap_sat,
    input  logic                 code_error_in,
    output jtimer_pkg::elapsed_t elapsed,
    output logic                 overflow,
    output logic                 code_error,
    output logic                 done
);
    import jtimer_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            elapsed    <= '0;
            overflow   <= 1'b0;
            code_error <= 1'b0;
            done       <= 1'b0;
        end else begin
            // One-cycle pulse following the capture edge
            done <= capture;
            if (capture) begin
                // Wrap count sits above the in-cycle position
                elapsed    <= {wrap_count, position};
                overflow   <= wrap_sat;
                code_error <= code_error_in;
            end
        end
    end

endmodule : interval_capture

`default_nettype wire

// ==== src/interval_fsm.sv ====
// Idle, run and done control for the interval timer
// Turns start, stop and tick strobes into clear, count and capture
`timescale 1ns/100ps
`default_nettype none

module interval_fsm (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  stop,
    input  logic  tick,
    timer_if.ctrl bus,
    output logic  capture,
    output logic  busy
);
    import jtimer_pkg::*;

    fsm_state_t state;
    fsm_state_t state_nxt;

    // ------------------------------------------------------------------------
    // Strobes
    // ------------------------------------------------------------------------
    // Start is only honoured outside a run
    assign bus.clear    = start && (state != ST_RUN);
    // Tick in the stop cycle is dropped
    assign bus.count_en = tick && !stop && (state == ST_RUN);
    assign capture      = stop && (state == ST_RUN);
    // Moore output
    assign busy         = (state == ST_RUN);

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                // Start while running has no effect
                if (stop) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                // Back to idle unless a new interval starts right away
                state_nxt = start ? ST_RUN : ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // A run only begins on the edge that clears the counter
    a_run_starts_cleared : assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(bus.clear)
    ) else $error("run entered without a counter clear");

endmodule : interval_fsm

`default_nettype wire

// ==== src/johnson_decode.sv ====
// Johnson code to binary step position, with an illegal-pattern flag
// Purely combinational, reads the code through the dec modport
`timescale 1ns/100ps
`default_nettype none

module johnson_decode (
    timer_if.dec             bus,
    output jtimer_pkg::pos_t position,
    output logic             code_error
);
    import jtimer_pkg::*;

    logic [$clog2(JT_WIDTH)-1:0] lead_idx;
    logic [$clog2(JT_WIDTH)-1:0] trail_idx;
    code_t                       lead_vec;
    code_t                       trail_vec;
    logic                        zero;
    logic                        nonzero;
    code_t                       run_low;
    code_t                       run_high;

    leading_one_trailing_one #(
        .WIDTH (JT_WIDTH)
    ) u_lot (
        .data               (bus.code),
        .leadingone         (lead_idx),
        .leadingone_vector  (lead_vec),
        .trailingone        (trail_idx),
        .trailingone_vector (trail_vec),
        .all_zeroes         (zero),
        .all_ones           (),
        .valid              (nonzero)
    );

    // ------------------------------------------------------------------------
    // Position
    // ------------------------------------------------------------------------
    always_comb begin
        if (bus.code[JT_WIDTH-1]) begin
            // Second half, ones drain from the bottom
            position = pos_t'(JT_WIDTH) + pos_t'(trail_idx);
        end else if (nonzero) begin
            // First half, ones fill from bit 0
            position = pos_t'(lead_idx) + pos_t'(1);
        end else begin
            position = '0;
        end
    end

    // ------------------------------------------------------------------------
    // Legal pattern check
    // ------------------------------------------------------------------------
    always_comb begin
        // Ones from bit 0 up to and including the leading one
        run_low  = lead_vec | (lead_vec - code_t'(1));
        // Ones from the trailing one up to the top bit
        run_high = ~(trail_vec - code_t'(1));
        if (bus.code[JT_WIDTH-1]) begin
            code_error = (bus.code != run_high);
        end else begin
            code_error = !zero && (bus.code != run_low);
        end
    end

endmodule : johnson_decode

`default_nettype wire

// ==== src/johnson_counter.sv ====
// Johnson shift counter with a saturating count of completed cycles
// Driven through the cnt modport, clear and count_en from the FSM
`timescale 1ns/100ps
`default_nettype none

module johnson_counter (
    input logic  clk,
    input logic  rst_n,
    timer_if.cnt bus
);
    import jtimer_pkg::*;

    localparam wrap_t WRAP_MAX = '1;

    // Last step of a cycle has only the top bit set
    logic wrap;

    assign wrap = bus.count_en && (bus.code == {1'b1, {(JT_WIDTH-1){1'b0}}});

    // ------------------------------------------------------------------------
    // Shift register and wrap counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.code       <= '0;
            bus.wrap_count <= '0;
            bus.wrap_sat   <= 1'b0;
        end else if (bus.clear) begin
            // Fresh interval starts at step zero
            bus.code       <= '0;
            bus.wrap_count <= '0;
            bus.wrap_sat   <= 1'b0;
        end else if (bus.count_en) begin
            // Shift left, inverted top bit re-enters at bit 0
            bus.code <= {bus.code[JT_WIDTH-2:0], ~bus.code[JT_WIDTH-1]};
            if (wrap) begin
                // Hold at the top and remember the lost cycle
                if (bus.wrap_count == WRAP_MAX) begin
                    bus.wrap_sat <= 1'b1;
                end else begin
                    bus.wrap_count <= bus.wrap_count + 1'b1;
                end
            end
        end
    end

    // FSM never asks to clear and count in the same cycle
    a_no_clear_and_count : assert property (
        @(posedge clk) disable iff (!rst_n) !(bus.clear && bus.count_en)
    ) else $error("clear and count_en both high");

endmodule : johnson_counter

`default_nettype wire

// ==== src/timer_if.sv ====
// Counter control and counter state shared by the FSM, counter and decoder
// Instantiate once in the top level and hand each block its modport
`timescale 1ns/100ps
`default_nettype none

interface timer_if;
    import jtimer_pkg::*;

    // Control from the FSM
    logic  clear;
    logic  count_en;

    // State from the counter
    code_t code;
    wrap_t wrap_count;
    logic  wrap_sat;

    // FSM side
    modport ctrl (output clear, output count_en);

    // Counter side
    modport cnt (input clear, input count_en,
                 output code, output wrap_count, output wrap_sat);

    // Decoder sees the raw code only
    modport dec (input code);

endinterface : timer_if

`default_nettype wire

// ==== src/leading_one_trailing_one.sv ====
// Leading and trailing one detector with indices, one-hot marks and flags
// Used by the Johnson decoder to locate the edges of the ones run
`timescale 1ns/100ps
`default_nettype none

module leading_one_trailing_one #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         data,
    output logic [$clog2(WIDTH)-1:0] leadingone,
    output logic [WIDTH-1:0]         leadingone_vector,
    output logic [$clog2(WIDTH)-1:0] trailingone,
    output logic [WIDTH-1:0]         trailingone_vector,
    output logic                     all_zeroes,
    output logic                     all_ones,
    output logic                     valid
);

    // Highest set bit gives the leading one
    find_last_set #(
        .WIDTH (WIDTH)
    ) u_find_last_set (
        .data  (data),
        .index (leadingone)
    );

    // Lowest set bit gives the trailing one
    find_first_set #(
        .WIDTH (WIDTH)
    ) u_find_first_set (
        .data  (data),
        .index (trailingone)
    );

    // ------------------------------------------------------------------------
    // One-hot marks
    // ------------------------------------------------------------------------
    always_comb begin
        leadingone_vector  = '0;
        trailingone_vector = '0;
        // Scanner index is 0 on empty input and must not set a mark
        if (valid) begin
            leadingone_vector[leadingone]   = 1'b1;
            trailingone_vector[trailingone] = 1'b1;
        end
    end

    // Reduction flags
    assign all_ones   = &data;
    assign all_zeroes = ~(|data);
    assign valid      = |data;

    // Marks feed the run-boundary check downstream
    // Each mark is one-hot for nonzero data and sits on the outermost ones
    always_comb begin
        assert (($onehot(leadingone_vector) == valid) && ($onehot(trailingone_vector) == valid))
            else $error("one-hot mark is not a single bit for nonzero data");
        assert (((leadingone_vector | trailingone_vector) & ~data) == '0)
            else $error("one-hot mark sits on a zero data bit");
        assert ((data & ~(leadingone_vector | (leadingone_vector - 1'b1))) == '0)
            else $error("data bit set above the leading one");
        assert ((data & (trailingone_vector - 1'b1)) == '0)
            else $error("data bit set below the trailing one");
    end

endmodule : leading_one_trailing_one

`default_nettype wire

// ==== src/bit_scan.sv ====
// Priority bit-index scanners for the lowest and the highest set bit
// Both return 0 for an all-zero input, so pair them with a zero flag
`timescale 1ns/100ps
`default_nettype none

// ---------------------------------------------------------------------------
// Lowest set bit
// ---------------------------------------------------------------------------
module find_first_set #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         data,
    output logic [$clog2(WIDTH)-1:0] index
);
    localparam int N = $clog2(WIDTH);

    always_comb begin
        index = '0;
        // Walk down from the top so the lowest hit is written last
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (data[i]) begin
                index = N'(i);
            end
        end
    end
endmodule : find_first_set

// ---------------------------------------------------------------------------
// Highest set bit
// ---------------------------------------------------------------------------
module find_last_set #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         data,
    output logic [$clog2(WIDTH)-1:0] index
);
    localparam int N = $clog2(WIDTH);

    always_comb begin
        index = '0;
        // Walk up from bit 0 so the highest hit wins
        for (int i = 0; i < WIDTH; i++) begin
            if (data[i]) begin
                index = N'(i);
            end
        end
    end
endmodule : find_last_set

`default_nettype wire

// ==== src/jtimer_pkg.sv ====
// Shared types for the tick interval timer
// Import wildcard inside a module body or use scoped names in a port list
`default_nettype none

`include "jtimer_config.svh"

package jtimer_pkg;

    // Sizes pulled from the config header
    localparam int JT_WIDTH  = `JT_WIDTH;
    localparam int JT_STEPS  = 2 * JT_WIDTH;
    localparam int POS_BITS  = $clog2(JT_STEPS);
    localparam int WRAP_BITS = `JT_WRAP_BITS;

    // Raw Johnson code
    typedef logic [JT_WIDTH-1:0] code_t;
    // Step position within one Johnson cycle
    typedef logic [POS_BITS-1:0] pos_t;
    // Completed Johnson cycles, saturating
    typedef logic [WRAP_BITS-1:0] wrap_t;
    // Wrap count packed above the position
    typedef logic [WRAP_BITS+POS_BITS-1:0] elapsed_t;

    // Control FSM states
    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} fsm_state_t;

endpackage : jtimer_pkg

`default_nettype wire

// ==== src/jtimer_config.svh ====
// Build-time sizes for the tick interval timer
// Included by the package and the top level
`ifndef JTIMER_CONFIG_SVH
`define JTIMER_CONFIG_SVH

// ---------------------------------------------------------------------------
// Johnson counter size
// ---------------------------------------------------------------------------
// Number of Johnson code bits, one cycle is twice this many steps
// Twice the width must be a power of two so wrap and position pack cleanly
`define JT_WIDTH 8

// Width of the wrap counter above the Johnson position
`define JT_WRAP_BITS 4

`endif
